//--- Makefile
# Verilator build and run for the AXI subordinate guard

VERILATOR ?= verilator
TOP       ?= tb_slv_guard
RTL_TOP   ?= slv_guard_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+.
slv_guard_pkg.sv
slv_guard_wr_mon.sv
slv_guard_rd_mon.sv
slv_guard_log_arb.sv
slv_guard_regs.sv
slv_guard_top.sv
tb_slv_guard_checker.sv
tb_slv_guard.sv

//--- slv_guard_log_arb.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard, error log arbiter
// Round-robin between write and read monitor records
////////////////////////////////////////////////////////////

module slv_guard_log_arb (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    wr_req_i,
  input  logic                    rd_req_i,
  input  slv_guard_pkg::err_rec_t wr_rec_i,
  input  slv_guard_pkg::err_rec_t rd_rec_i,
  output logic                    wr_gnt_o,
  output logic                    rd_gnt_o,
  output logic                    log_wr_o,
  output slv_guard_pkg::err_rec_t log_rec_o
);

  // Read side won the last grant
  logic last_rd_q;

  assign wr_gnt_o  = wr_req_i && (!rd_req_i || last_rd_q);
  assign rd_gnt_o  = rd_req_i && (!wr_req_i || !last_rd_q);
  assign log_wr_o  = wr_gnt_o || rd_gnt_o;
  assign log_rec_o = rd_gnt_o ? rd_rec_i : wr_rec_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_rd_q <= 1'b0;
    end else if (log_wr_o) begin
      last_rd_q <= rd_gnt_o;
    end
  end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_gnt_o && rd_gnt_o))
    else $error("both log grants high");

  // A losing monitor holds its request and wins next cycle
  a_wr_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_req_i && !wr_gnt_o |=> wr_gnt_o)
    else $error("write record waited more than one cycle");

  a_rd_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_req_i && !rd_gnt_o |=> rd_gnt_o)
    else $error("read record waited more than one cycle");

endmodule

//--- slv_guard_macros.svh
////////////////////////////////////////////////////////////
// AXI subordinate guard, shared widths and register map
////////////////////////////////////////////////////////////

`ifndef SLV_GUARD_MACROS_SVH
`define SLV_GUARD_MACROS_SVH

// AXI widths
`define SG_ID_W            2
`define SG_ADDR_W          32
`define SG_DATA_W          32

// Timer width and tracking depths
`define SG_CNT_W           16
`define SG_MAX_TXNS_PER_ID 4
`define SG_LOG_DEPTH       4

// Register bus
`define SG_REG_AW          8
`define SG_REG_CTRL        8'h00
`define SG_REG_WR_BUDGET   8'h04
`define SG_REG_RD_BUDGET   8'h08
`define SG_REG_ERR_CNT     8'h0C
`define SG_REG_ERR_POP     8'h10

`endif

//--- slv_guard_pkg.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard types
// Channel and bus structs, error record, slot state
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

package slv_guard_pkg;

  typedef logic [`SG_ID_W-1:0]     axi_id_t;
  typedef logic [`SG_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`SG_DATA_W-1:0]   axi_data_t;
  typedef logic [`SG_DATA_W/8-1:0] axi_strb_t;
  typedef logic [7:0]              axi_len_t;
  typedef logic [1:0]              axi_resp_t;
  typedef logic [`SG_CNT_W-1:0]    cnt_t;
  typedef logic [`SG_REG_AW-1:0]   reg_addr_t;
  typedef logic [31:0]             reg_data_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } aw_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } ar_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_rsp_t;

  typedef struct packed {
    reg_addr_t addr;
    logic      write;
    reg_data_t wdata;
    logic      valid;
  } reg_req_t;

  typedef struct packed {
    reg_data_t rdata;
    logic      error;
    logic      ready;
  } reg_rsp_t;

  typedef struct packed {
    logic    is_read;
    axi_id_t id;
  } err_rec_t;

  typedef enum logic [1:0] {
    slot_idle,
    slot_busy,
    slot_expired
  } slot_state_e;

endpackage

//--- slv_guard_rd_mon.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard, read monitor
// Times open reads per ID from AR to last R, flags timeouts
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

module slv_guard_rd_mon (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ena_i,
  input  slv_guard_pkg::axi_req_t req_i,
  input  slv_guard_pkg::axi_rsp_t rsp_i,
  input  slv_guard_pkg::cnt_t     budget_i,
  output logic                    err_req_o,
  output slv_guard_pkg::err_rec_t err_rec_o,
  input  logic                    err_gnt_i
);

  localparam int unsigned NUM_IDS = 1 << `SG_ID_W;
  localparam int unsigned OCNT_W  = $clog2(`SG_MAX_TXNS_PER_ID + 1);

  logic [OCNT_W-1:0]          ocnt_q  [NUM_IDS];
  logic [OCNT_W-1:0]          ocnt_d  [NUM_IDS];
  slv_guard_pkg::cnt_t        timer_q [NUM_IDS];
  slv_guard_pkg::slot_state_e state_q [NUM_IDS];

  logic                   ar_hs;
  logic                   r_hs;
  logic [NUM_IDS-1:0]     start_hit;
  logic [NUM_IDS-1:0]     end_hit;
  logic [NUM_IDS-1:0]     hit;
  slv_guard_pkg::axi_id_t hit_id;
  logic                   take;
  logic                   pend_q;
  slv_guard_pkg::axi_id_t pend_id_q;
  slv_guard_pkg::axi_id_t err_id_q;

  assign ar_hs = req_i.ar_valid & rsp_i.ar_ready;
  // Only the last beat closes a burst
  assign r_hs  = rsp_i.r_valid & req_i.r_ready & rsp_i.r.last;

  always_comb begin
    hit_id = '0;
    for (int i = NUM_IDS - 1; i >= 0; i--) begin
      start_hit[i] = ar_hs && req_i.ar.id == slv_guard_pkg::axi_id_t'(i);
      end_hit[i]   = r_hs && rsp_i.r.id == slv_guard_pkg::axi_id_t'(i);
      ocnt_d[i]    = ocnt_q[i] + OCNT_W'(start_hit[i]) - OCNT_W'(end_hit[i]);
      hit[i]       = ena_i && budget_i != '0 && state_q[i] == slv_guard_pkg::slot_busy
                     && timer_q[i] >= budget_i;
      if (hit[i]) begin
        hit_id = slv_guard_pkg::axi_id_t'(i);
      end
    end
  end

  assign take = |hit && !pend_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        ocnt_q[i]  <= '0;
        timer_q[i] <= '0;
        state_q[i] <= slv_guard_pkg::slot_idle;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        ocnt_q[i] <= ocnt_d[i];
        if (!ena_i || ocnt_d[i] == '0 || end_hit[i] ||
            (start_hit[i] && ocnt_q[i] == '0)) begin
          timer_q[i] <= '0;
        end else if (timer_q[i] != '1) begin
          timer_q[i] <= timer_q[i] + 1'b1;
        end
        if (ocnt_d[i] == '0) begin
          state_q[i] <= slv_guard_pkg::slot_idle;
        end else if (take && hit_id == slv_guard_pkg::axi_id_t'(i)) begin
          state_q[i] <= slv_guard_pkg::slot_expired;
        end else if (state_q[i] == slv_guard_pkg::slot_idle) begin
          state_q[i] <= slv_guard_pkg::slot_busy;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_req_o <= 1'b0;
      pend_q    <= 1'b0;
    end else if (!err_req_o || err_gnt_i) begin
      err_req_o <= pend_q || take;
      pend_q    <= 1'b0;
    end else if (take) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!err_req_o || err_gnt_i) begin
      err_id_q <= pend_q ? pend_id_q : hit_id;
    end
    if (take) begin
      pend_id_q <= hit_id;
    end
  end

  assign err_rec_o = '{is_read: 1'b1, id: err_id_q};

  a_r_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_hs |-> ocnt_q[rsp_i.r.id] != '0)
    else $error("last R for id %0d without open read", rsp_i.r.id);

endmodule

//--- slv_guard_regs.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard, register file
// Budgets, control, error log FIFO, count, irq and reset req
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

module slv_guard_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  slv_guard_pkg::reg_req_t reg_req_i,
  output slv_guard_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    log_wr_i,
  input  slv_guard_pkg::err_rec_t log_rec_i,
  output slv_guard_pkg::cnt_t     wr_budget_o,
  output slv_guard_pkg::cnt_t     rd_budget_o,
  output logic                    irq_o,
  output logic                    rst_req_o
);

  localparam int unsigned PTR_W = $clog2(`SG_LOG_DEPTH);

  logic [1:0]               ctrl_q;
  slv_guard_pkg::cnt_t      wr_budget_q;
  slv_guard_pkg::cnt_t      rd_budget_q;
  slv_guard_pkg::reg_data_t err_cnt_q;
  logic                     irq_q;
  logic                     rst_req_q;

  slv_guard_pkg::err_rec_t  log_mem [`SG_LOG_DEPTH];
  // Extra MSB tells full from empty
  logic [PTR_W:0]           wptr_q;
  logic [PTR_W:0]           rptr_q;
  logic                     log_full;
  logic                     log_empty;
  slv_guard_pkg::err_rec_t  head;

  logic                     wr_en;
  logic                     rd_en;
  logic                     clr;
  logic                     pop;
  logic                     push;

  assign log_empty = wptr_q == rptr_q;
  assign log_full  = wptr_q[PTR_W] != rptr_q[PTR_W] &&
                     wptr_q[PTR_W-1:0] == rptr_q[PTR_W-1:0];
  assign head      = log_mem[rptr_q[PTR_W-1:0]];

  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign rd_en = reg_req_i.valid && !reg_req_i.write;
  // Any write to ERR_CNT clears the whole error state
  assign clr   = wr_en && reg_req_i.addr == `SG_REG_ERR_CNT;
  assign pop   = rd_en && reg_req_i.addr == `SG_REG_ERR_POP && !log_empty;
  assign push  = log_wr_i && !log_full && !clr;

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.ready = reg_req_i.valid;
    case (reg_req_i.addr)
      `SG_REG_CTRL:      reg_rsp_o.rdata = slv_guard_pkg::reg_data_t'(ctrl_q);
      `SG_REG_WR_BUDGET: reg_rsp_o.rdata = slv_guard_pkg::reg_data_t'(wr_budget_q);
      `SG_REG_RD_BUDGET: reg_rsp_o.rdata = slv_guard_pkg::reg_data_t'(rd_budget_q);
      `SG_REG_ERR_CNT:   reg_rsp_o.rdata = err_cnt_q;
      `SG_REG_ERR_POP: begin
        reg_rsp_o.rdata     = slv_guard_pkg::reg_data_t'(head);
        reg_rsp_o.rdata[31] = !log_empty;
      end
      default:           reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q      <= '0;
      wr_budget_q <= '0;
      rd_budget_q <= '0;
      err_cnt_q   <= '0;
      wptr_q      <= '0;
      rptr_q      <= '0;
      irq_q       <= 1'b0;
      rst_req_q   <= 1'b0;
    end else begin
      if (wr_en) begin
        case (reg_req_i.addr)
          `SG_REG_CTRL:      ctrl_q      <= reg_req_i.wdata[1:0];
          `SG_REG_WR_BUDGET: wr_budget_q <= reg_req_i.wdata[`SG_CNT_W-1:0];
          `SG_REG_RD_BUDGET: rd_budget_q <= reg_req_i.wdata[`SG_CNT_W-1:0];
          default: ;
        endcase
      end
      if (clr) begin
        err_cnt_q <= '0;
        wptr_q    <= '0;
        rptr_q    <= '0;
        irq_q     <= 1'b0;
        rst_req_q <= 1'b0;
      end else begin
        if (pop) begin
          rptr_q <= rptr_q + 1'b1;
        end
        if (push) begin
          wptr_q <= wptr_q + 1'b1;
        end
        // Dropped records are still counted
        if (log_wr_i) begin
          if (err_cnt_q != '1) begin
            err_cnt_q <= err_cnt_q + 1'b1;
          end
          if (ctrl_q[0]) begin
            irq_q <= 1'b1;
          end
          if (ctrl_q[1]) begin
            rst_req_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      log_mem[wptr_q[PTR_W-1:0]] <= log_rec_i;
    end
  end

  assign wr_budget_o = wr_budget_q;
  assign rd_budget_o = rd_budget_q;
  assign irq_o       = irq_q;
  assign rst_req_o   = rst_req_q;

endmodule

//--- slv_guard_top.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard, top level
// Zero-latency pass-through with write and read timeout watch
////////////////////////////////////////////////////////////

module slv_guard_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    guard_ena_i,
  // Manager side
  input  slv_guard_pkg::axi_req_t req_i,
  output slv_guard_pkg::axi_rsp_t rsp_o,
  // Subordinate side
  output slv_guard_pkg::axi_req_t req_o,
  input  slv_guard_pkg::axi_rsp_t rsp_i,
  input  slv_guard_pkg::reg_req_t reg_req_i,
  output slv_guard_pkg::reg_rsp_t reg_rsp_o,
  output logic                    irq_o,
  output logic                    rst_req_o
);

  slv_guard_pkg::cnt_t     wr_budget;
  slv_guard_pkg::cnt_t     rd_budget;
  logic                    wr_err_req;
  logic                    rd_err_req;
  slv_guard_pkg::err_rec_t wr_err_rec;
  slv_guard_pkg::err_rec_t rd_err_rec;
  logic                    wr_err_gnt;
  logic                    rd_err_gnt;
  logic                    log_wr;
  slv_guard_pkg::err_rec_t log_rec;

  // Observe only, never touch the traffic
  assign req_o = req_i;
  assign rsp_o = rsp_i;

  slv_guard_wr_mon i_wr_mon (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .ena_i     ( guard_ena_i ),
    .req_i     ( req_i       ),
    .rsp_i     ( rsp_i       ),
    .budget_i  ( wr_budget   ),
    .err_req_o ( wr_err_req  ),
    .err_rec_o ( wr_err_rec  ),
    .err_gnt_i ( wr_err_gnt  )
  );

  slv_guard_rd_mon i_rd_mon (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .ena_i     ( guard_ena_i ),
    .req_i     ( req_i       ),
    .rsp_i     ( rsp_i       ),
    .budget_i  ( rd_budget   ),
    .err_req_o ( rd_err_req  ),
    .err_rec_o ( rd_err_rec  ),
    .err_gnt_i ( rd_err_gnt  )
  );

  slv_guard_log_arb i_log_arb (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .wr_req_i  ( wr_err_req ),
    .rd_req_i  ( rd_err_req ),
    .wr_rec_i  ( wr_err_rec ),
    .rd_rec_i  ( rd_err_rec ),
    .wr_gnt_o  ( wr_err_gnt ),
    .rd_gnt_o  ( rd_err_gnt ),
    .log_wr_o  ( log_wr     ),
    .log_rec_o ( log_rec    )
  );

  slv_guard_regs i_regs (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .reg_req_i   ( reg_req_i ),
    .reg_rsp_o   ( reg_rsp_o ),
    .log_wr_i    ( log_wr    ),
    .log_rec_i   ( log_rec   ),
    .wr_budget_o ( wr_budget ),
    .rd_budget_o ( rd_budget ),
    .irq_o       ( irq_o     ),
    .rst_req_o   ( rst_req_o )
  );

endmodule

//--- slv_guard_wr_mon.sv
////////////////////////////////////////////////////////////
// AXI subordinate guard, write monitor
// Times open writes per ID from AW to B, flags timeouts
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

module slv_guard_wr_mon (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ena_i,
  input  slv_guard_pkg::axi_req_t req_i,
  input  slv_guard_pkg::axi_rsp_t rsp_i,
  input  slv_guard_pkg::cnt_t     budget_i,
  output logic                    err_req_o,
  output slv_guard_pkg::err_rec_t err_rec_o,
  input  logic                    err_gnt_i
);

  localparam int unsigned NUM_IDS = 1 << `SG_ID_W;
  localparam int unsigned OCNT_W  = $clog2(`SG_MAX_TXNS_PER_ID + 1);

  logic [OCNT_W-1:0]          ocnt_q  [NUM_IDS];
  logic [OCNT_W-1:0]          ocnt_d  [NUM_IDS];
  slv_guard_pkg::cnt_t        timer_q [NUM_IDS];
  slv_guard_pkg::slot_state_e state_q [NUM_IDS];

  logic                   aw_hs;
  logic                   b_hs;
  logic [NUM_IDS-1:0]     start_hit;
  logic [NUM_IDS-1:0]     end_hit;
  logic [NUM_IDS-1:0]     hit;
  slv_guard_pkg::axi_id_t hit_id;
  logic                   take;
  logic                   pend_q;
  slv_guard_pkg::axi_id_t pend_id_q;
  slv_guard_pkg::axi_id_t err_id_q;

  assign aw_hs = req_i.aw_valid & rsp_i.aw_ready;
  assign b_hs  = rsp_i.b_valid & req_i.b_ready;

  always_comb begin
    hit_id = '0;
    // Descending scan so the lowest expiring ID wins
    for (int i = NUM_IDS - 1; i >= 0; i--) begin
      start_hit[i] = aw_hs && req_i.aw.id == slv_guard_pkg::axi_id_t'(i);
      end_hit[i]   = b_hs && rsp_i.b.id == slv_guard_pkg::axi_id_t'(i);
      ocnt_d[i]    = ocnt_q[i] + OCNT_W'(start_hit[i]) - OCNT_W'(end_hit[i]);
      hit[i]       = ena_i && budget_i != '0 && state_q[i] == slv_guard_pkg::slot_busy
                     && timer_q[i] >= budget_i;
      if (hit[i]) begin
        hit_id = slv_guard_pkg::axi_id_t'(i);
      end
    end
  end

  // One expiry accepted per cycle, only while the pending slot is free
  assign take = |hit && !pend_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        ocnt_q[i]  <= '0;
        timer_q[i] <= '0;
        state_q[i] <= slv_guard_pkg::slot_idle;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        ocnt_q[i] <= ocnt_d[i];
        if (!ena_i || ocnt_d[i] == '0 || end_hit[i] ||
            (start_hit[i] && ocnt_q[i] == '0)) begin
          timer_q[i] <= '0;
        end else if (timer_q[i] != '1) begin
          timer_q[i] <= timer_q[i] + 1'b1;
        end
        if (ocnt_d[i] == '0) begin
          state_q[i] <= slv_guard_pkg::slot_idle;
        end else if (take && hit_id == slv_guard_pkg::axi_id_t'(i)) begin
          state_q[i] <= slv_guard_pkg::slot_expired;
        end else if (state_q[i] == slv_guard_pkg::slot_idle) begin
          state_q[i] <= slv_guard_pkg::slot_busy;
        end
      end
    end
  end

  // Output request, backed by a one-deep pending entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_req_o <= 1'b0;
      pend_q    <= 1'b0;
    end else if (!err_req_o || err_gnt_i) begin
      err_req_o <= pend_q || take;
      pend_q    <= 1'b0;
    end else if (take) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!err_req_o || err_gnt_i) begin
      err_id_q <= pend_q ? pend_id_q : hit_id;
    end
    if (take) begin
      pend_id_q <= hit_id;
    end
  end

  assign err_rec_o = '{is_read: 1'b0, id: err_id_q};

  // Manager keeps within the per-ID limit
  a_max_txns: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_hs && ocnt_q[req_i.aw.id] == OCNT_W'(`SG_MAX_TXNS_PER_ID)
    |-> b_hs && rsp_i.b.id == req_i.aw.id)
    else $error("write limit exceeded for id %0d", req_i.aw.id);

  a_b_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_hs |-> ocnt_q[rsp_i.b.id] != '0)
    else $error("B for id %0d without open write", rsp_i.b.id);

endmodule

//--- tb_slv_guard.sv
////////////////////////////////////////////////////////////
// Testbench for the AXI subordinate guard
// Table-driven manager, subordinate model and watchdog
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

module tb_slv_guard;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int K_WR = 0;
  localparam int K_RD = 1;
  localparam int K_BOTH = 2;
  localparam int NUM_ROWS = 7;

  // Expected records packed as {is_read, id}, record k in bits 3k+2..3k
  typedef struct {
    int          kind;
    int          id;
    int          reps;
    int          delay;
    int          budget;
    int          ctrl;
    bit          ena;
    int          exp_cnt;
    bit          exp_irq;
    bit          exp_rst;
    int          exp_n;
    logic [11:0] recs;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    guard_ena;
  slv_guard_pkg::axi_req_t req;
  slv_guard_pkg::axi_rsp_t rsp;
  slv_guard_pkg::axi_req_t req_out;
  slv_guard_pkg::axi_rsp_t rsp_out;
  slv_guard_pkg::reg_req_t reg_req;
  slv_guard_pkg::reg_rsp_t reg_rsp;
  logic                    irq;
  logic                    rst_req;

  row_t        rows [NUM_ROWS];
  integer      seed = 19;
  logic        row_done;
  logic        all_done;
  int          row_idx;
  int          exp_cnt;
  logic        exp_irq;
  logic        exp_rst;
  int          exp_n;
  logic [11:0] exp_recs;
  int          chk_errors;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  slv_guard_top dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .guard_ena_i ( guard_ena ),
    .req_i       ( req       ),
    .rsp_o       ( rsp_out   ),
    .req_o       ( req_out   ),
    .rsp_i       ( rsp       ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .irq_o       ( irq       ),
    .rst_req_o   ( rst_req   )
  );

  tb_slv_guard_checker chk (
    .clk_i      ( clk        ),
    .rst_n_i    ( rst_n      ),
    .req_i      ( req        ),
    .rsp_o      ( rsp_out    ),
    .req_o      ( req_out    ),
    .rsp_i      ( rsp        ),
    .reg_req_i  ( reg_req    ),
    .reg_rsp_o  ( reg_rsp    ),
    .irq_o      ( irq        ),
    .rst_req_o  ( rst_req    ),
    .row_done_i ( row_done   ),
    .row_i      ( row_idx    ),
    .exp_cnt_i  ( exp_cnt    ),
    .exp_irq_i  ( exp_irq    ),
    .exp_rst_i  ( exp_rst    ),
    .exp_n_i    ( exp_n      ),
    .exp_recs_i ( exp_recs   ),
    .done_i     ( all_done   ),
    .errors_o   ( chk_errors )
  );

  task automatic fill_table();
    // In-budget write and read
    rows[0] = '{K_WR,   1, 1, 5,  10, 1, 1'b1, 0, 1'b0, 1'b0, 0, 12'h000};
    rows[1] = '{K_RD,   2, 1, 5,  10, 1, 1'b1, 0, 1'b0, 1'b0, 0, 12'h000};
    // Write timeout, then write and read together
    rows[2] = '{K_WR,   1, 1, 30, 10, 1, 1'b1, 1, 1'b1, 1'b0, 1, 12'h001};
    rows[3] = '{K_BOTH, 3, 1, 30, 10, 3, 1'b1, 2, 1'b1, 1'b1, 2, 12'h03B};
    // Reset request only, then guard disabled
    rows[4] = '{K_WR,   0, 1, 30, 10, 2, 1'b1, 1, 1'b0, 1'b1, 1, 12'h000};
    rows[5] = '{K_WR,   2, 1, 30, 10, 1, 1'b0, 0, 1'b0, 1'b0, 0, 12'h000};
    // Five timeouts into a four-entry log
    rows[6] = '{K_WR,   1, 5, 30, 10, 1, 1'b1, 5, 1'b1, 1'b0, 4, 12'h249};
  endtask

  task automatic reg_write(input slv_guard_pkg::reg_addr_t addr, input int data);
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = 32'(data);
    @(negedge clk);
    reg_req.valid = 1'b0;
  endtask

  task automatic reg_read(input slv_guard_pkg::reg_addr_t addr);
    @(negedge clk);
    reg_req.valid = 1'b1;
    reg_req.write = 1'b0;
    reg_req.addr  = addr;
    @(negedge clk);
    reg_req.valid = 1'b0;
  endtask

  task automatic write_txn(input int id);
    @(negedge clk);
    req.aw_valid = 1'b1;
    req.aw.id    = slv_guard_pkg::axi_id_t'(id);
    req.aw.addr  = $random(seed);
    req.aw.len   = '0;
    req.w_valid  = 1'b1;
    req.w.data   = $random(seed);
    req.w.strb   = '1;
    req.w.last   = 1'b1;
    @(negedge clk);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
  endtask

  task automatic read_txn(input int id);
    @(negedge clk);
    req.ar_valid = 1'b1;
    req.ar.id    = slv_guard_pkg::axi_id_t'(id);
    req.ar.addr  = $random(seed);
    req.ar.len   = '0;
    @(negedge clk);
    req.ar_valid = 1'b0;
  endtask

  // Subordinate model, answers after the row delay
  task automatic respond_b(input int id, input int delay);
    do @(posedge clk); while (!(req.aw_valid && rsp.aw_ready));
    repeat (delay) @(posedge clk);
    @(negedge clk);
    rsp.b_valid = 1'b1;
    rsp.b.id    = slv_guard_pkg::axi_id_t'(id);
    rsp.b.resp  = '0;
    @(negedge clk);
    rsp.b_valid = 1'b0;
  endtask

  task automatic respond_r(input int id, input int delay);
    do @(posedge clk); while (!(req.ar_valid && rsp.ar_ready));
    repeat (delay) @(posedge clk);
    @(negedge clk);
    rsp.r_valid = 1'b1;
    rsp.r.id    = slv_guard_pkg::axi_id_t'(id);
    rsp.r.data  = $random(seed);
    rsp.r.resp  = '0;
    rsp.r.last  = 1'b1;
    @(negedge clk);
    rsp.r_valid = 1'b0;
  endtask

  task automatic run_row(input int r);
    reg_write(`SG_REG_ERR_CNT, 0);
    reg_write(`SG_REG_CTRL, rows[r].ctrl);
    reg_write(`SG_REG_WR_BUDGET, rows[r].budget);
    reg_write(`SG_REG_RD_BUDGET, rows[r].budget);
    @(negedge clk);
    guard_ena = rows[r].ena;
    repeat (rows[r].reps) begin
      fork
        if (rows[r].kind != K_RD) write_txn(rows[r].id);
        if (rows[r].kind != K_RD) respond_b(rows[r].id, rows[r].delay);
        if (rows[r].kind != K_WR) read_txn(rows[r].id);
        if (rows[r].kind != K_WR) respond_r(rows[r].id, rows[r].delay);
      join
    end
    repeat (4) @(posedge clk);
    reg_read(`SG_REG_ERR_CNT);
    repeat (rows[r].exp_n + 1) reg_read(`SG_REG_ERR_POP);
    @(negedge clk);
    row_idx  = r;
    exp_cnt  = rows[r].exp_cnt;
    exp_irq  = rows[r].exp_irq;
    exp_rst  = rows[r].exp_rst;
    exp_n    = rows[r].exp_n;
    exp_recs = rows[r].recs;
    row_done = 1'b1;
    @(negedge clk);
    row_done = 1'b0;
  endtask

  task automatic watchdog();
    int limit;
    int max_delay;
    max_delay = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].delay > max_delay) max_delay = rows[r].delay;
    end
    limit = NUM_ROWS * 5 * (max_delay + 30) + 200;
    repeat (limit) @(posedge clk);
    $display("Run stopped by watchdog after %0d cycles", limit);
    $display("Regression failed");
    $finish;
  endtask

  initial begin
    rst_n     = 1'b0;
    guard_ena = 1'b0;
    req       = '0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    rsp       = '0;
    rsp.aw_ready = 1'b1;
    rsp.w_ready  = 1'b1;
    rsp.ar_ready = 1'b1;
    reg_req   = '0;
    row_done  = 1'b0;
    all_done  = 1'b0;
    row_idx   = 0;
    exp_cnt   = 0;
    exp_irq   = 1'b0;
    exp_rst   = 1'b0;
    exp_n     = 0;
    exp_recs  = '0;
    fill_table();
    fork
      watchdog();
    join_none
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    // Unmapped offset
    reg_read(8'h20);
    @(negedge clk);
    all_done = 1'b1;
    @(negedge clk);
    all_done = 1'b0;
    if (chk_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb_slv_guard_checker.sv
////////////////////////////////////////////////////////////
// Checker for the AXI subordinate guard testbench
// Snoops DUT ports and compares against row expectations
////////////////////////////////////////////////////////////

`include "slv_guard_macros.svh"

module tb_slv_guard_checker (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  slv_guard_pkg::axi_req_t req_i,
  input  slv_guard_pkg::axi_rsp_t rsp_o,
  input  slv_guard_pkg::axi_req_t req_o,
  input  slv_guard_pkg::axi_rsp_t rsp_i,
  input  slv_guard_pkg::reg_req_t reg_req_i,
  input  slv_guard_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    irq_o,
  input  logic                    rst_req_o,
  input  logic                    row_done_i,
  input  int                      row_i,
  input  int                      exp_cnt_i,
  input  logic                    exp_irq_i,
  input  logic                    exp_rst_i,
  input  int                      exp_n_i,
  input  logic [11:0]             exp_recs_i,
  input  logic                    done_i,
  output int                      errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int                       row_errs = 0;
  int                       rows_ok = 0;
  int                       rows_bad = 0;
  slv_guard_pkg::reg_data_t pops [$];
  slv_guard_pkg::reg_data_t cnt_rd = '0;
  logic                     irq_seen = 1'b0;
  logic                     rst_seen = 1'b0;
  logic                     clr_q = 1'b0;

  initial errors_o = 0;

  task automatic wrong_value(input string name, input logic [127:0] exp, input logic [127:0] got);
    $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    errors_o++;
    row_errs++;
  endtask

  task automatic report(input string msg);
    $display("Failure at %0d ns: %s", $time, msg);
    errors_o++;
    row_errs++;
  endtask

  function automatic logic is_mapped(input slv_guard_pkg::reg_addr_t addr);
    return addr == `SG_REG_CTRL || addr == `SG_REG_WR_BUDGET || addr == `SG_REG_RD_BUDGET ||
           addr == `SG_REG_ERR_CNT || addr == `SG_REG_ERR_POP;
  endfunction

  task automatic check_row();
    slv_guard_pkg::err_rec_t got [$];
    slv_guard_pkg::err_rec_t want;
    int idx [$];
    if (cnt_rd != 32'(exp_cnt_i)) wrong_value("ERR_CNT", 128'(exp_cnt_i), 128'(cnt_rd));
    if (irq_o !== exp_irq_i) wrong_value("irq_o", 128'(exp_irq_i), 128'(irq_o));
    if (rst_req_o !== exp_rst_i) wrong_value("rst_req_o", 128'(exp_rst_i), 128'(rst_req_o));
    if (!exp_irq_i && irq_seen) report("irq_o went high during the row");
    if (!exp_rst_i && rst_seen) report("rst_req_o went high during the row");
    if (pops.size() != exp_n_i + 1) begin
      report("wrong number of ERR_POP reads seen");
    end else begin
      for (int k = 0; k < exp_n_i; k++) begin
        if (!pops[k][31]) report("ERR_POP valid flag missing on a logged record");
        got.push_back(slv_guard_pkg::err_rec_t'(pops[k][2:0]));
      end
      if (pops[exp_n_i][31]) report("ERR_POP valid flag set on an empty log");
      // Records may come out in either order
      for (int k = 0; k < exp_n_i; k++) begin
        want = slv_guard_pkg::err_rec_t'(exp_recs_i[3*k +: 3]);
        idx = got.find_first_index(x) with (x == want);
        if (idx.size() == 0) begin
          report($sformatf("record %0h missing from the ERR_POP reads", want));
        end else begin
          got.delete(idx[0]);
        end
      end
    end
    pops.delete();
    if (row_errs == 0) begin
      rows_ok++;
      $display("row %0d: ok", row_i);
    end else begin
      rows_bad++;
      $display("row %0d: %0d mismatches", row_i, row_errs);
    end
    row_errs = 0;
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (req_o !== req_i) wrong_value("req_o", 128'(req_i), 128'(req_o));
      if (rsp_o !== rsp_i) wrong_value("rsp_o", 128'(rsp_i), 128'(rsp_o));
      if (clr_q && irq_o) wrong_value("irq_o", 128'(0), 128'(irq_o));
      if (clr_q && rst_req_o) wrong_value("rst_req_o", 128'(0), 128'(rst_req_o));
      clr_q = 1'b0;
      irq_seen = irq_seen | irq_o;
      rst_seen = rst_seen | rst_req_o;
      if (reg_req_i.valid) begin
        if (!reg_rsp_o.ready) report("register bus ready low with valid high");
        if (reg_rsp_o.error !== !is_mapped(reg_req_i.addr)) begin
          wrong_value("reg error", 128'(!is_mapped(reg_req_i.addr)), 128'(reg_rsp_o.error));
        end
        if (reg_req_i.write && reg_req_i.addr == `SG_REG_ERR_CNT) begin
          clr_q    = 1'b1;
          irq_seen = 1'b0;
          rst_seen = 1'b0;
        end
        if (!reg_req_i.write && reg_req_i.addr == `SG_REG_ERR_CNT) cnt_rd = reg_rsp_o.rdata;
        if (!reg_req_i.write && reg_req_i.addr == `SG_REG_ERR_POP) begin
          pops.push_back(reg_rsp_o.rdata);
        end
      end
      if (row_done_i) check_row();
      if (done_i) begin
        $display("%0d rows ok, %0d rows failed, %0d errors", rows_ok, rows_bad, errors_o);
      end
    end
  end

endmodule
